// ==== panel_ctrl.f ====
+incdir+verif
logic/panel_pkg.sv
logic/cmd_decoder.sv
logic/pixel_writer.sv
logic/panel_blanker.sv
logic/panel_ctrl_top.sv
verif/panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the panel controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 --top-module panel_tb -f panel_ctrl.f -o panel_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/panel_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== verif/panel_model.svh ====
// *************************************************************************
// reference model of the colour and brightness registers, expected frame
// RAM contents and the xorshift generator
// *************************************************************************
localparam int RAM_DEPTH = 1 << $bits(ram_addr_t);

// 0 to 5 colour, 6 to 13 brightness, 14 takes an argument
localparam logic [7:0] REG_OPS [15] = '{
    RED_ENABLE, RED_DISABLE, GREEN_ENABLE, GREEN_DISABLE, BLUE_ENABLE, BLUE_DISABLE,
    BRIGHTNESS_ZERO, BRIGHTNESS_ONE, BRIGHTNESS_TWO, BRIGHTNESS_THREE, BRIGHTNESS_FOUR,
    BRIGHTNESS_FIVE, BRIGHTNESS_SIX, BRIGHTNESS_NINE, READBRIGHTNESS
};

rgb_en_t     model_rgb;
brightness_t model_bright;
logic [7:0]  model_ram [RAM_DEPTH];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// bytes never written keep a value tied to their whole address
function automatic logic [7:0] fill_pattern(input ram_addr_t addr);
    logic [11:0] word;
    word = addr;
    return word[7:0] ^ 8'(word >> 4) ^ 8'h5a;
endfunction

function automatic void model_reset();
    model_rgb = '1;
    model_bright = '1;
    for (int i = 0; i < RAM_DEPTH; i++) begin
        model_ram[12'(i)] = fill_pattern(ram_addr_t'(12'(i)));
    end
endfunction

function automatic logic is_known_opcode(input logic [7:0] op);
    logic known;
    known = (op == READPIXEL) || (op == BLANKPANEL);
    for (int i = 0; i < 15; i++) begin
        known = known || (op == REG_OPS[4'(i)]);
    end
    return known;
endfunction

function automatic void model_opcode(input logic [7:0] op);
    case (op)
        RED_ENABLE:       model_rgb.red = 1'b1;
        RED_DISABLE:      model_rgb.red = 1'b0;
        GREEN_ENABLE:     model_rgb.green = 1'b1;
        GREEN_DISABLE:    model_rgb.green = 1'b0;
        BLUE_ENABLE:      model_rgb.blue = 1'b1;
        BLUE_DISABLE:     model_rgb.blue = 1'b0;
        // level one is the most significant bit
        BRIGHTNESS_ONE:   model_bright[BRIGHTNESS_LEVELS-1] ^= 1'b1;
        BRIGHTNESS_TWO:   model_bright[BRIGHTNESS_LEVELS-2] ^= 1'b1;
        BRIGHTNESS_THREE: model_bright[BRIGHTNESS_LEVELS-3] ^= 1'b1;
        BRIGHTNESS_FOUR:  model_bright[BRIGHTNESS_LEVELS-4] ^= 1'b1;
        BRIGHTNESS_FIVE:  model_bright[BRIGHTNESS_LEVELS-5] ^= 1'b1;
        BRIGHTNESS_SIX:   model_bright[BRIGHTNESS_LEVELS-6] ^= 1'b1;
        BRIGHTNESS_ZERO:  model_bright = '0;
        BRIGHTNESS_NINE:  model_bright = '1;
        default: ;
    endcase
endfunction

function automatic void model_write_pixel(input logic [7:0] row, col, colour_hi, colour_lo);
    ram_addr_t addr;
    addr.row = ROW_BITS'(row);
    addr.col = COL_BITS'(col);
    // first colour byte on select 1
    addr.byte_sel = 1'b1;
    model_ram[addr] = colour_hi;
    addr.byte_sel = 1'b0;
    model_ram[addr] = colour_lo;
endfunction

function automatic void model_blank(input int width, input int height);
    for (int r = 0; r < height; r++) begin
        for (int c = 0; c < width; c++) begin
            for (int s = 0; s < BYTES_PER_PIXEL; s++) begin
                model_ram[{ROW_BITS'(r), COL_BITS'(c), 1'(s)}] = 8'h00;
            end
        end
    end
endfunction

// ==== verif/panel_tb.sv ====
// *************************************************************************
// panel controller testbench, random commands checked against a model
// *************************************************************************
`timescale 1ns/1ns

module panel_tb;
    import panel_pkg::*;

    localparam int PANEL_W = 8;
    localparam int PANEL_H = 4;
    localparam logic [31:0] SEED = 32'd15;
    localparam int NUM_CMDS = 60;
    localparam int NUM_PIXELS = 24;
    localparam int READY_TIMEOUT = 16;
    localparam int BLANK_TIMEOUT = 2 * PANEL_W * PANEL_H + 16;

    logic        clk_in;
    logic        reset;
    cmd_byte_u   data_in;
    logic        data_valid;
    logic        ready_for_data;
    rgb_en_t     rgb_enable;
    brightness_t brightness;
    ram_wr_t     ram_wr;

    logic [31:0] rng_state;
    int          write_count;
    int          errors;
    int          checks;
    int          tests;

    `include "panel_model.svh"

    logic [7:0] captured_ram [RAM_DEPTH];

    panel_ctrl_top #(
        .PIXEL_WIDTH  (PANEL_W),
        .PIXEL_HEIGHT (PANEL_H)
    ) dut (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .ready_for_data (ready_for_data),
        .rgb_enable     (rgb_enable),
        .brightness     (brightness),
        .ram_wr         (ram_wr)
    );

    always #4 clk_in = ~clk_in;

    // frame RAM seen through the write port, sampled mid cycle
    always @(negedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                captured_ram[12'(i)] = fill_pattern(ram_addr_t'(12'(i)));
            end
            write_count = 0;
        end else if (ram_wr.write_enable) begin
            captured_ram[ram_wr.addr] = ram_wr.data;
            write_count++;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_rgb(input rgb_en_t expected);
        checks++;
        if (rgb_enable !== expected) begin
            errors++;
            $display("FAILED at %0t: rgb_enable is %b, expected %b", $time, rgb_enable, expected);
        end
    endtask

    task automatic check_brightness(input brightness_t expected);
        checks++;
        if (brightness !== expected) begin
            errors++;
            $display("FAILED at %0t: brightness is %b, expected %b", $time, brightness, expected);
        end
    endtask

    task automatic check_ram_byte(input ram_addr_t addr, input logic [7:0] expected);
        checks++;
        if (captured_ram[addr] !== expected) begin
            errors++;
            $display("FAILED at %0t: ram row %0d col %0d sel %0d is %h, expected %h",
                $time, addr.row, addr.col, addr.byte_sel, captured_ram[addr], expected);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // holds the byte until the decoder takes it
    task automatic send_byte(input logic [7:0] value);
        int waited;
        waited = 0;
        data_in.arg = value;
        data_valid = 1'b1;
        @(negedge clk_in);
        while (!ready_for_data && waited < READY_TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        if (!ready_for_data) begin
            errors++;
            $display("ERROR at %0t: byte %h was never accepted", $time, value);
        end
        @(posedge clk_in);
        #1;
        data_valid = 1'b0;
    endtask

    task automatic wait_ready(input logic level, input int limit);
        int waited;
        waited = 0;
        @(negedge clk_in);
        while (ready_for_data !== level && waited < limit) begin
            @(negedge clk_in);
            waited++;
        end
        if (ready_for_data !== level) begin
            errors++;
            $display("ERROR at %0t: ready_for_data did not reach %b within %0d cycles",
                $time, level, limit);
        end
    endtask

    task automatic run_reg_cmd(input logic bright_cmd);
        logic [7:0] op;
        logic [7:0] arg;
        op = bright_cmd ? REG_OPS[4'(6 + next_rand() % 9)] : REG_OPS[4'(next_rand() % 6)];
        send_byte(op);
        if (op == READBRIGHTNESS) begin
            arg = 8'(next_rand());
            send_byte(arg);
            model_bright = arg[BRIGHTNESS_LEVELS-1:0];
        end else begin
            model_opcode(op);
        end
        check_rgb(model_rgb);
        check_brightness(model_bright);
    endtask

    task automatic write_pixel();
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] colour_hi;
        logic [7:0] colour_lo;
        ram_addr_t  addr;
        int         start_writes;
        row = 8'(next_rand() % PANEL_H);
        col = 8'(next_rand() % PANEL_W);
        colour_hi = 8'(next_rand());
        colour_lo = 8'(next_rand());
        start_writes = write_count;
        send_byte(READPIXEL);
        send_byte(row);
        send_byte(col);
        send_byte(colour_hi);
        send_byte(colour_lo);
        model_write_pixel(row, col, colour_hi, colour_lo);
        // second write comes one cycle after the last byte
        @(posedge clk_in);
        #1;
        check_count("pixel write count", start_writes + 2, write_count);
        addr = {ROW_BITS'(row), COL_BITS'(col), 1'b1};
        check_ram_byte(addr, model_ram[addr]);
        addr.byte_sel = 1'b0;
        check_ram_byte(addr, model_ram[addr]);
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - start_errors);
        end
    endtask

    initial begin
        int         start_errors;
        int         start_writes;
        logic [7:0] op;
        ram_addr_t  addr;
        clk_in = 1'b0;
        reset = 1'b1;
        data_in.arg = 8'h00;
        data_valid = 1'b0;
        rng_state = SEED;
        errors = 0;
        checks = 0;
        tests = 0;
        model_reset();
        repeat (16) @(posedge clk_in);
        #1;
        reset = 1'b0;

        start_errors = errors;
        check_rgb(model_rgb);
        check_brightness(model_bright);
        check_flag("write_enable", ram_wr.write_enable, 1'b0);
        check_flag("ready_for_data", ready_for_data, 1'b1);
        report_test("reset state", start_errors);

        start_errors = errors;
        repeat (NUM_CMDS) run_reg_cmd(1'b0);
        report_test("colour enables", start_errors);

        start_errors = errors;
        repeat (NUM_CMDS) run_reg_cmd(1'b1);
        report_test("brightness", start_errors);

        start_errors = errors;
        repeat (NUM_PIXELS) write_pixel();
        report_test("pixel writes", start_errors);

        start_errors = errors;
        repeat (8) write_pixel();
        start_writes = write_count;
        send_byte(BLANKPANEL);
        model_blank(PANEL_W, PANEL_H);
        wait_ready(1'b0, READY_TIMEOUT);
        wait_ready(1'b1, BLANK_TIMEOUT);
        @(posedge clk_in);
        #1;
        check_count("blank write count", start_writes + 2 * PANEL_W * PANEL_H, write_count);
        for (int r = 0; r < PANEL_H; r++) begin
            for (int c = 0; c < PANEL_W; c++) begin
                for (int s = 0; s < BYTES_PER_PIXEL; s++) begin
                    addr = {ROW_BITS'(r), COL_BITS'(c), 1'(s)};
                    check_ram_byte(addr, model_ram[addr]);
                end
            end
        end
        report_test("blank panel", start_errors);

        start_errors = errors;
        repeat (NUM_CMDS) begin
            case (next_rand() % 3)
                0: begin
                    do begin
                        op = 8'(next_rand());
                    end while (is_known_opcode(op));
                    start_writes = write_count;
                    send_byte(op);
                    @(posedge clk_in);
                    #1;
                    check_rgb(model_rgb);
                    check_brightness(model_bright);
                    check_count("unknown opcode write count", start_writes, write_count);
                end
                1: run_reg_cmd(1'(next_rand()));
                default: write_pixel();
            endcase
        end
        report_test("unknown opcodes", start_errors);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== logic/panel_ctrl_top.sv ====
// *************************************************************************
// panel controller top level, command decoder plus pixel and blank writers
// *************************************************************************
`timescale 1ns/1ns

module panel_ctrl_top #(
    parameter int unsigned PIXEL_WIDTH = panel_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = panel_pkg::DEFAULT_PIXEL_HEIGHT
) (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::cmd_byte_u   data_in,
    input  logic                   data_valid,
    output logic                   ready_for_data,
    output panel_pkg::rgb_en_t     rgb_enable,
    output panel_pkg::brightness_t brightness,
    output panel_pkg::ram_wr_t     ram_wr
);
    import panel_pkg::*;

    logic       pix_start;
    logic       blank_start;
    logic [7:0] arg_byte;
    logic       arg_valid;
    ram_wr_t    pix_wr;
    ram_wr_t    blank_wr;
    logic       pix_done;
    logic       blank_done;

    cmd_decoder u_decoder (
        .clk_in         (clk_in),
        .reset          (reset),
        .data_in        (data_in),
        .data_valid     (data_valid),
        .ready_for_data (ready_for_data),
        .rgb_enable     (rgb_enable),
        .brightness     (brightness),
        .pix_start      (pix_start),
        .blank_start    (blank_start),
        .arg_byte       (arg_byte),
        .arg_valid      (arg_valid),
        .pix_wr         (pix_wr),
        .blank_wr       (blank_wr),
        .pix_done       (pix_done),
        .blank_done     (blank_done),
        .ram_wr         (ram_wr)
    );

    pixel_writer #(
        .PIXEL_WIDTH  (PIXEL_WIDTH),
        .PIXEL_HEIGHT (PIXEL_HEIGHT)
    ) u_pixel_writer (
        .clk_in    (clk_in),
        .reset     (reset),
        .pix_start (pix_start),
        .arg_byte  (arg_byte),
        .arg_valid (arg_valid),
        .pix_wr    (pix_wr),
        .pix_done  (pix_done)
    );

    // sweeps without input, decoder holds off the source meanwhile
    panel_blanker #(
        .PIXEL_WIDTH  (PIXEL_WIDTH),
        .PIXEL_HEIGHT (PIXEL_HEIGHT)
    ) u_panel_blanker (
        .clk_in      (clk_in),
        .reset       (reset),
        .blank_start (blank_start),
        .blank_wr    (blank_wr),
        .blank_done  (blank_done)
    );

endmodule

// ==== logic/panel_blanker.sv ====
// *************************************************************************
// panel blanker, one zero write per cycle over every row, column and byte
// *************************************************************************
`timescale 1ns/1ns

module panel_blanker #(
    parameter int unsigned PIXEL_WIDTH = panel_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = panel_pkg::DEFAULT_PIXEL_HEIGHT
) (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               blank_start,
    output panel_pkg::ram_wr_t blank_wr,
    output logic               blank_done
);
    import panel_pkg::*;

    logic                running;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;
    logic                sel_q;
    logic                sel_last;
    logic                col_last;
    logic                row_last;

    assign sel_last = (sel_q == 1'(BYTES_PER_PIXEL - 1));
    assign col_last = (col_q == COL_BITS'(PIXEL_WIDTH - 1));
    assign row_last = (row_q == ROW_BITS'(PIXEL_HEIGHT - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            running <= 1'b0;
            row_q <= '0;
            col_q <= '0;
            sel_q <= 1'b0;
        end else if (blank_start) begin
            running <= 1'b1;
            row_q <= '0;
            col_q <= '0;
            sel_q <= 1'b0;
        end else if (running) begin
            sel_q <= ~sel_q;
            if (sel_last) begin
                col_q <= col_last ? '0 : col_q + 1'b1;
                if (col_last) begin
                    row_q <= row_q + 1'b1;
                    running <= !row_last;
                end
            end
        end
    end

    always_comb begin
        blank_wr.write_enable = running;
        blank_wr.addr.row = row_q;
        blank_wr.addr.col = col_q;
        blank_wr.addr.byte_sel = sel_q;
        blank_wr.data = 8'h00;
    end

    assign blank_done = running && row_last && col_last && sel_last;

    // decoder holds ready low for the whole sweep
    a_no_restart: assert property (@(posedge clk_in) disable iff (reset)
        blank_start |-> !running);

endmodule

// ==== logic/pixel_writer.sv ====
// *************************************************************************
// READPIXEL argument collector, row and column latch, two byte writes
// *************************************************************************
`timescale 1ns/1ns

module pixel_writer #(
    parameter int unsigned PIXEL_WIDTH = panel_pkg::DEFAULT_PIXEL_WIDTH,
    parameter int unsigned PIXEL_HEIGHT = panel_pkg::DEFAULT_PIXEL_HEIGHT
) (
    input  logic               clk_in,
    input  logic               reset,
    input  logic               pix_start,
    input  logic [7:0]         arg_byte,
    input  logic               arg_valid,
    output panel_pkg::ram_wr_t pix_wr,
    output logic               pix_done
);
    import panel_pkg::*;

    // 0 row, 1 column, 2 and 3 colour bytes
    logic [1:0]          arg_cnt;
    logic [ROW_BITS-1:0] row_q;
    logic [COL_BITS-1:0] col_q;
    logic                we_q;
    logic                done_q;
    ram_addr_t           addr_q;
    logic [7:0]          data_q;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            arg_cnt <= 2'd0;
            we_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            we_q <= arg_valid && arg_cnt[1];
            done_q <= arg_valid && (arg_cnt == 2'd3);
            if (pix_start) begin
                arg_cnt <= 2'd0;
            end else if (arg_valid) begin
                arg_cnt <= arg_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            case (arg_cnt)
                2'd0: row_q <= arg_byte[ROW_BITS-1:0];
                2'd1: col_q <= arg_byte[COL_BITS-1:0];
                default: begin
                    addr_q.row <= row_q;
                    addr_q.col <= col_q;
                    // inverted byte index, first colour byte lands on select 1
                    addr_q.byte_sel <= ~arg_cnt[0];
                    data_q <= arg_byte;
                end
            endcase
        end
    end

    always_comb begin
        pix_wr.write_enable = we_q;
        pix_wr.addr = addr_q;
        pix_wr.data = data_q;
    end

    assign pix_done = done_q;

    // the source is trusted to send in-range coordinates
    a_pixel_in_panel: assert property (@(posedge clk_in) disable iff (reset)
        pix_wr.write_enable |->
            (32'(pix_wr.addr.row) < PIXEL_HEIGHT) && (32'(pix_wr.addr.col) < PIXEL_WIDTH));

endmodule

// ==== logic/cmd_decoder.sv ====
// *************************************************************************
// command FSM with colour and brightness registers, input handshake
// and selection of the active RAM writer
// *************************************************************************
`timescale 1ns/1ns

module cmd_decoder (
    input  logic                   clk_in,
    input  logic                   reset,
    input  panel_pkg::cmd_byte_u   data_in,
    input  logic                   data_valid,
    output logic                   ready_for_data,
    output panel_pkg::rgb_en_t     rgb_enable,
    output panel_pkg::brightness_t brightness,
    output logic                   pix_start,
    output logic                   blank_start,
    output logic [7:0]             arg_byte,
    output logic                   arg_valid,
    input  panel_pkg::ram_wr_t     pix_wr,
    input  panel_pkg::ram_wr_t     blank_wr,
    input  logic                   pix_done,
    input  logic                   blank_done,
    output panel_pkg::ram_wr_t     ram_wr
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHT_ARG,
        ST_PIXEL,
        ST_BLANK
    } dec_state_e;

    dec_state_e state;
    logic       accept;
    logic       opcode_phase;

    // only the blank sweep pushes back on the source
    assign ready_for_data = (state != ST_BLANK);
    assign accept = data_valid && ready_for_data;

    // last colour write still in flight, the next byte is already an opcode
    assign opcode_phase = (state == ST_IDLE) || ((state == ST_PIXEL) && pix_done);

    assign pix_start = accept && opcode_phase && (data_in.opcode == READPIXEL);
    assign blank_start = accept && opcode_phase && (data_in.opcode == BLANKPANEL);
    assign arg_valid = accept && (state == ST_PIXEL) && !pix_done;
    assign arg_byte = data_in.arg;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
            rgb_enable <= '1;
            brightness <= '1;
        end else begin
            case (state)
                ST_BRIGHT_ARG: begin
                    if (accept) begin
                        brightness <= data_in.arg[BRIGHTNESS_LEVELS-1:0];
                        state <= ST_IDLE;
                    end
                end
                ST_PIXEL: begin
                    if (pix_done) begin
                        state <= ST_IDLE;
                    end
                end
                ST_BLANK: begin
                    if (blank_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                end
            endcase

            if (accept && opcode_phase) begin
                case (data_in.opcode)
                    RED_ENABLE:       rgb_enable.red <= 1'b1;
                    RED_DISABLE:      rgb_enable.red <= 1'b0;
                    GREEN_ENABLE:     rgb_enable.green <= 1'b1;
                    GREEN_DISABLE:    rgb_enable.green <= 1'b0;
                    BLUE_ENABLE:      rgb_enable.blue <= 1'b1;
                    BLUE_DISABLE:     rgb_enable.blue <= 1'b0;
                    // level one is the top bit
                    BRIGHTNESS_ONE: begin
                        brightness[BRIGHTNESS_LEVELS-1] <= ~brightness[BRIGHTNESS_LEVELS-1];
                    end
                    BRIGHTNESS_TWO: begin
                        brightness[BRIGHTNESS_LEVELS-2] <= ~brightness[BRIGHTNESS_LEVELS-2];
                    end
                    BRIGHTNESS_THREE: begin
                        brightness[BRIGHTNESS_LEVELS-3] <= ~brightness[BRIGHTNESS_LEVELS-3];
                    end
                    BRIGHTNESS_FOUR: begin
                        brightness[BRIGHTNESS_LEVELS-4] <= ~brightness[BRIGHTNESS_LEVELS-4];
                    end
                    BRIGHTNESS_FIVE: begin
                        brightness[BRIGHTNESS_LEVELS-5] <= ~brightness[BRIGHTNESS_LEVELS-5];
                    end
                    BRIGHTNESS_SIX: begin
                        brightness[BRIGHTNESS_LEVELS-6] <= ~brightness[BRIGHTNESS_LEVELS-6];
                    end
                    BRIGHTNESS_ZERO:  brightness <= '0;
                    BRIGHTNESS_NINE:  brightness <= '1;
                    READBRIGHTNESS:   state <= ST_BRIGHT_ARG;
                    READPIXEL:        state <= ST_PIXEL;
                    BLANKPANEL:       state <= ST_BLANK;
                    // unknown opcodes fall through
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        case (state)
            ST_PIXEL: ram_wr = pix_wr;
            ST_BLANK: ram_wr = blank_wr;
            default:  ram_wr = '0;
        endcase
    end

    // a writer may only drive the RAM while its command is running
    a_quiet_when_idle: assert property (@(posedge clk_in) disable iff (reset)
        (state == ST_IDLE) |-> !(pix_wr.write_enable || blank_wr.write_enable));

endmodule

// ==== logic/panel_pkg.sv ====
// *************************************************************************
// command opcodes, input byte union, brightness and colour enable types,
// frame RAM address and write port structs, panel geometry constants
// *************************************************************************
package panel_pkg;

    localparam int BRIGHTNESS_LEVELS = 6;
    // RGB565, two bytes per pixel
    localparam int BYTES_PER_PIXEL = 2;

    // address fields sized for a 64x32 panel
    localparam int ROW_BITS = 5;
    localparam int COL_BITS = 6;

    localparam int DEFAULT_PIXEL_WIDTH = 8;
    localparam int DEFAULT_PIXEL_HEIGHT = 4;

    typedef enum logic [7:0] {
        RED_ENABLE       = 8'h52,
        RED_DISABLE      = 8'h72,
        GREEN_ENABLE     = 8'h47,
        GREEN_DISABLE    = 8'h67,
        BLUE_ENABLE      = 8'h42,
        BLUE_DISABLE     = 8'h62,
        BRIGHTNESS_ZERO  = 8'h30,
        BRIGHTNESS_ONE   = 8'h31,
        BRIGHTNESS_TWO   = 8'h32,
        BRIGHTNESS_THREE = 8'h33,
        BRIGHTNESS_FOUR  = 8'h34,
        BRIGHTNESS_FIVE  = 8'h35,
        BRIGHTNESS_SIX   = 8'h36,
        BRIGHTNESS_NINE  = 8'h39,
        READBRIGHTNESS   = 8'h54,
        READPIXEL        = 8'h50,
        BLANKPANEL       = 8'h5a
    } opcode_e;

    // opcode when idle, raw argument while a command collects bytes
    typedef union packed {
        opcode_e    opcode;
        logic [7:0] arg;
    } cmd_byte_u;

    // msb is the most significant level
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef struct packed {
        logic blue;
        logic green;
        logic red;
    } rgb_en_t;

    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic                byte_sel;
    } ram_addr_t;

    typedef struct packed {
        logic       write_enable;
        ram_addr_t  addr;
        logic [7:0] data;
    } ram_wr_t;

endpackage
